/* hdl/mac_pkg.sv */
// Address field typedefs, mode enum, ECC window and page table depth constants
`default_nettype none

package mac_pkg;

  // Field widths
  localparam int ICA_W   = 16;  // CPU logical address
  localparam int PCR_W   = 16;  // Paging control register
  localparam int SEG_W   = 8;   // Segment field of a PTE
  localparam int XPT_W   = 2;   // Extended page bits
  localparam int PTIX_W  = 6;   // Page index, ica[15:10]
  localparam int LA_W    = 14;  // LA[23:10]

  // Table size, one entry per logical page
  localparam int PT_DEPTH = 64;

  // ECC register window as seen on LA[15:10]
  localparam logic [5:0] ECCR_WINDOW = 6'b100000;

  typedef logic [ICA_W-1:0]  ica_t;
  typedef logic [PCR_W-1:0]  pcr_t;       // Bits 14..7 carry paging fields
  typedef logic [SEG_W-1:0]  seg_t;
  typedef logic [XPT_W-1:0]  xpt_t;
  typedef logic [PTIX_W-1:0] pt_index_t;

  // Entry layout is {xpt, seg}, xpt in the top two bits
  typedef logic [XPT_W+SEG_W-1:0] pt_entry_t;

  // Index 0 is LA10, index 13 is LA23
  typedef logic [LA_W-1:0] la_t;

  // Address mode as classified from poni/double/shadow/mreq/xpt_en
  typedef enum logic [2:0] {
    MODE_DIRECT     = 3'd0,  // Paging off
    MODE_DOUBLE     = 3'd1,  // Paging off, word address shifted
    MODE_PAGED      = 3'd2,  // Normal page table lookup
    MODE_EXTPAGE    = 3'd3,  // Page table with extended bits
    MODE_SHADOW_MEM = 3'd4,  // Shadow memory access
    MODE_SHADOW_IO  = 3'd5   // Shadow IO access
  } mac_mode_t;

endpackage

`default_nettype wire

/* hdl/mac_mode_decode.sv */
// mac_mode_decode module, mode classification and LA mux select strobes
`timescale 1ns/1ps
`default_nettype none

module mac_mode_decode
  import mac_pkg::*;
(
  input  logic poni,    // Paging on
  input  logic double,  // Double word addressing
  input  logic shadow,  // Shadow access
  input  logic mreq,    // Memory request, else IO
  input  logic xpt_en,  // Extended page table enable
  output logic a10,     // ica[5:0] onto LA[15:10], ica[7:6] onto LA[17:16]
  output logic bb10,    // Same, shifted up one bit
  output logic c10,     // ica[15:10] onto LA[15:10]
  output logic a1617,   // seg[1:0] onto LA[17:16], seg[7:6] onto LA[23:22]
  output logic d1617,   // pcr[10:9] onto LA[17:16]
  output logic e1617,   // pcr[8:7] onto LA[17:16]
  output logic f1617,   // xpt onto LA[17:16]
  output logic a1619,   // pcr[12:11] and inverted pcr[14:13]
  output logic a1819,   // Inverted ica[10:9] onto LA[19:18]
  output logic b1819,   // Inverted pcr[10:9] onto LA[19:18]
  output logic b1821    // seg[5:2] onto LA[21:18]
);

  mac_mode_t mode;

  // Priority classification, first match wins
  always_comb
  begin
    if (!poni && !double)
      mode = MODE_DIRECT;
    else if (!poni)
      mode = MODE_DOUBLE;
    else if (shadow && (double || mreq))
      mode = MODE_SHADOW_MEM;  // double picks the PCR low field below
    else if (shadow)
      mode = MODE_SHADOW_IO;
    else if (!xpt_en)
      mode = MODE_PAGED;
    else
      mode = MODE_EXTPAGE;
  end

  // One strobe group per mode
  always_comb
  begin
    a10   = 1'b0;
    bb10  = 1'b0;
    c10   = 1'b0;
    a1617 = 1'b0;
    d1617 = 1'b0;
    e1617 = 1'b0;
    f1617 = 1'b0;
    a1619 = 1'b0;
    a1819 = 1'b0;
    b1819 = 1'b0;
    b1821 = 1'b0;
    case (mode)
      MODE_DIRECT:
      begin
        a10   = 1'b1;
        a1819 = 1'b1;
      end
      MODE_DOUBLE:
      begin
        bb10  = 1'b1;
        b1819 = 1'b1;
      end
      MODE_SHADOW_MEM:
      begin
        c10   = 1'b1;
        d1617 = double;   // PCR low field variant
        a1619 = !double;
      end
      MODE_SHADOW_IO:
      begin
        c10   = 1'b1;
        e1617 = 1'b1;
      end
      MODE_PAGED:
      begin
        a1617 = 1'b1;
        b1821 = 1'b1;
      end
      MODE_EXTPAGE:
      begin
        f1617 = 1'b1;
        b1821 = 1'b1;
      end
      default: ;  // Unused encodings leave all strobes low
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mac_page_table.sv */
// mac_page_table module, 64-entry segment and extension table
`timescale 1ns/1ps
`default_nettype none

module mac_page_table
  import mac_pkg::*;
(
  input  logic      mclk,
  input  logic      rst_n,
  input  logic      pt_we,     // Write strobe
  input  pt_index_t pt_waddr,  // Write index
  input  pt_entry_t pt_wdata,  // {xpt, seg}
  input  pt_index_t rd_index,  // Read index, ica[15:10]
  output seg_t      seg,
  output xpt_t      xpt
);

  pt_entry_t table_q [PT_DEPTH];
  pt_entry_t rd_entry;

  // Writes land on the rising edge
  // Reset clears every entry so paged modes start at segment zero
  always_ff @(posedge mclk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < PT_DEPTH; i++)
        table_q[i] <= '0;
    end
    else if (pt_we)
    begin
      table_q[pt_waddr] <= pt_wdata;
    end
  end

  // Asynchronous read
  assign rd_entry = table_q[rd_index];

  // Split entry into its fields
  assign seg = rd_entry[SEG_W-1:0];
  assign xpt = rd_entry[SEG_W+XPT_W-1:SEG_W];  // Top bits

endmodule

`default_nettype wire

/* hdl/mac_la_mux.sv */
// mac_la_mux module, LA[23:10] sum-of-products mux, LA register, ECC window detect
`timescale 1ns/1ps
`default_nettype none

module mac_la_mux
  import mac_pkg::*;
(
  input  logic mclk,
  input  logic rst_n,
  input  ica_t ica,         // CPU logical address
  input  pcr_t pcr,         // Paging control register
  input  seg_t seg,         // From page table
  input  xpt_t xpt,         // From page table
  input  logic a10,
  input  logic bb10,
  input  logic c10,
  input  logic a1617,
  input  logic d1617,
  input  logic e1617,
  input  logic f1617,
  input  logic a1619,
  input  logic a1819,
  input  logic b1819,
  input  logic b1821,
  output la_t  la,          // Registered LA[23:10]
  output logic eccr_hit_n   // Low when LA[15:10] hits ECCR window
);

  la_t ila;  // Next LA, bit 0 is LA10

  always_comb
  begin
    // LA15..10
    for (int i = 0; i < 6; i++)
    begin
      ila[i] = (ica[i] & a10)        // Direct
             | (ica[i+1] & bb10)     // Double
             | (ica[10+i] & c10);    // Shadow, page bits pass through
    end

    // LA17..16, one bit per pass
    for (int j = 0; j < 2; j++)
    begin
      ila[6+j] = (ica[6+j] & a10)
               | (ica[7+j] & bb10)
               | (pcr[11+j] & a1619)  // Shadow mem
               | (seg[j] & a1617)     // Paged
               | (pcr[9+j] & d1617)   // Shadow mem, PCR low field
               | (pcr[7+j] & e1617)   // Shadow IO
               | (xpt[j] & f1617);    // Extended paging
    end

    // LA18, inverted terms as in the gate array
    ila[8] = (~pcr[13] & a1619)
           | (~pcr[9] & b1819)
           | (seg[2] & b1821)
           | (~ica[9] & a1819);

    // LA19
    ila[9] = (~pcr[14] & a1619)
           | (~pcr[10] & b1819)
           | (seg[3] & b1821)
           | (~ica[10] & a1819);

    // LA21..20 only from paged and extended modes
    ila[10] = seg[4] & b1821;
    ila[11] = seg[5] & b1821;

    // LA23..22 only from plain paged mode
    ila[12] = seg[6] & a1617;
    ila[13] = seg[7] & a1617;
  end

  // LA register
  always_ff @(posedge mclk)
  begin
    if (!rst_n)
      la <= '0;
    else
      la <= ila;
  end

  // Window compare on registered LA[15:10]
  assign eccr_hit_n = (la[5:0] != ECCR_WINDOW);

endmodule

`default_nettype wire

/* hdl/mac_top.sv */
// mac_top module, address stage top joining mode decode, page table and LA mux
`timescale 1ns/1ps
`default_nettype none

module mac_top
  import mac_pkg::*;
(
  input  logic      mclk,
  input  logic      rst_n,
  input  logic      poni,
  input  logic      double,
  input  logic      shadow,
  input  logic      mreq,
  input  logic      xpt_en,
  input  ica_t      ica,
  input  pcr_t      pcr,
  input  logic      pt_we,
  input  pt_index_t pt_waddr,
  input  pt_entry_t pt_wdata,
  output la_t       la,
  output logic      eccr_hit_n
);

  // Strobes decoder to mux
  logic a10;
  logic bb10;
  logic c10;
  logic a1617;
  logic d1617;
  logic e1617;
  logic f1617;
  logic a1619;
  logic a1819;
  logic b1819;
  logic b1821;

  seg_t      seg;
  xpt_t      xpt;
  pt_index_t rd_index;

  assign rd_index = ica[15:10];  // Logical page number

  mac_mode_decode u_decode (
    .poni   (poni),
    .double (double),
    .shadow (shadow),
    .mreq   (mreq),
    .xpt_en (xpt_en),
    .a10    (a10),
    .bb10   (bb10),
    .c10    (c10),
    .a1617  (a1617),
    .d1617  (d1617),
    .e1617  (e1617),
    .f1617  (f1617),
    .a1619  (a1619),
    .a1819  (a1819),
    .b1819  (b1819),
    .b1821  (b1821)
  );

  mac_page_table u_pt (
    .mclk     (mclk),
    .rst_n    (rst_n),
    .pt_we    (pt_we),
    .pt_waddr (pt_waddr),
    .pt_wdata (pt_wdata),
    .rd_index (rd_index),
    .seg      (seg),
    .xpt      (xpt)
  );

  mac_la_mux u_mux (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .ica        (ica),
    .pcr        (pcr),
    .seg        (seg),
    .xpt        (xpt),
    .a10        (a10),
    .bb10       (bb10),
    .c10        (c10),
    .a1617      (a1617),
    .d1617      (d1617),
    .e1617      (e1617),
    .f1617      (f1617),
    .a1619      (a1619),
    .a1819      (a1819),
    .b1819      (b1819),
    .b1821      (b1821),
    .la         (la),
    .eccr_hit_n (eccr_hit_n)
  );

endmodule

`default_nettype wire

/* tests/tb_mac.sv */
// tb_mac testbench, directed and random address rows, page table writes, LA reference model
`timescale 1ns/1ps
`default_nettype none

module tb_mac
  import mac_pkg::*;
();

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_A        = 15;              // Rows before the table writes
  localparam int NUM_DIR      = 23;              // All directed rows
  localparam int NUM_RAND     = 48;
  localparam int NUM_ROWS     = NUM_DIR + NUM_RAND;
  localparam int NUM_WR_RAND  = 16;
  localparam int NUM_WR       = NUM_WR_RAND + 4; // Random writes followed by directed ones
  localparam int WDOG_CYCLES  = NUM_ROWS + NUM_WR + 20;

  // Mode bits are {poni, double, shadow, mreq, xpt_en}
  typedef struct packed {
    logic [4:0] mode;
    ica_t       ica;
    pcr_t       pcr;
    la_t        exp_la;
    logic       exp_hit_n;
  } row_t;

  logic      mclk;
  logic      rst_n;
  logic      poni;
  logic      double;
  logic      shadow;
  logic      mreq;
  logic      xpt_en;
  ica_t      ica;
  pcr_t      pcr;
  logic      pt_we;
  pt_index_t pt_waddr;
  pt_entry_t pt_wdata;
  la_t       la;
  logic      eccr_hit_n;

  row_t        rows [NUM_ROWS];
  pt_index_t   wr_addr [NUM_WR];
  pt_entry_t   wr_data [NUM_WR];
  pt_entry_t   mirror [PT_DEPTH];  // Table contents after all writes
  logic [31:0] rng;

  // Row waiting for its result one cycle later
  logic pend;
  int   pend_row;
  la_t  pend_la;
  logic pend_hit;

  int la_errs;
  int hit_errs;
  int other_errs;

  mac_top uut (
    .mclk       (mclk),
    .rst_n      (rst_n),
    .poni       (poni),
    .double     (double),
    .shadow     (shadow),
    .mreq       (mreq),
    .xpt_en     (xpt_en),
    .ica        (ica),
    .pcr        (pcr),
    .pt_we      (pt_we),
    .pt_waddr   (pt_waddr),
    .pt_wdata   (pt_wdata),
    .la         (la),
    .eccr_hit_n (eccr_hit_n)
  );

  initial
  begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // Expected LA[23:10] with one branch per address mode
  function automatic la_t model_la(input logic [4:0] m, input ica_t a, input pcr_t p,
                                   input pt_entry_t e);
    la_t  r;
    logic pg;
    logic dbl;
    logic shd;
    logic mrq;
    logic xen;
    {pg, dbl, shd, mrq, xen} = m;
    r = '0;
    if (!pg && !dbl)
    begin
      r[7:0] = a[7:0];  // Direct
      r[8]   = ~a[9];
      r[9]   = ~a[10];
    end
    else if (!pg)
    begin
      r[7:0] = a[8:1];  // Double shifted by one
      r[8]   = ~p[9];
      r[9]   = ~p[10];
    end
    else if (shd && dbl)
    begin
      r[5:0] = a[15:10];
      r[7:6] = p[10:9];  // PCR low field
    end
    else if (shd && mrq)
    begin
      r[5:0] = a[15:10];
      r[7:6] = p[12:11];
      r[8]   = ~p[13];
      r[9]   = ~p[14];
    end
    else if (shd)
    begin
      r[5:0] = a[15:10];  // Shadow IO
      r[7:6] = p[8:7];
    end
    else if (!xen)
      r[13:6] = e[7:0];   // Whole segment onto LA[23:16]
    else
    begin
      r[7:6]  = e[9:8];   // xpt
      r[11:8] = e[5:2];
    end
    return r;
  endfunction

  task automatic set_row(input int r, input logic [4:0] m, input ica_t a, input pcr_t p,
                         input la_t exp_la, input logic exp_hit_n);
    rows[r].mode      = m;
    rows[r].ica       = a;
    rows[r].pcr       = p;
    rows[r].exp_la    = exp_la;
    rows[r].exp_hit_n = exp_hit_n;
  endtask

  task automatic fill_tables();
    // Table still all zero before any write
    set_row(0,  5'b10000, 16'h1234, 16'hffff, 14'h0000, 1'b1);  // Paged with an empty entry
    set_row(1,  5'b00000, 16'h00a5, 16'h0000, 14'h03a5, 1'b1);  // Direct
    set_row(2,  5'b00000, 16'h06ff, 16'h0000, 14'h00ff, 1'b1);
    set_row(3,  5'b00000, 16'h0400, 16'h0000, 14'h0100, 1'b1);
    set_row(4,  5'b01000, 16'h014a, 16'h0200, 14'h02a5, 1'b1);  // Double
    set_row(5,  5'b01000, 16'h01fe, 16'h0600, 14'h00ff, 1'b1);
    set_row(6,  5'b11100, 16'h5400, 16'h0400, 14'h0095, 1'b1);  // Shadow mem with PCR low
    set_row(7,  5'b10110, 16'hfc00, 16'h2800, 14'h027f, 1'b1);  // Shadow mem
    set_row(8,  5'b10100, 16'h2c00, 16'h0180, 14'h00cb, 1'b1);  // Shadow IO
    set_row(9,  5'b10100, 16'h8000, 16'h0000, 14'h0020, 1'b0);  // At the window
    set_row(10, 5'b10100, 16'h7c00, 16'h0000, 14'h001f, 1'b1);  // One below
    set_row(11, 5'b10100, 16'h8400, 16'h0000, 14'h0021, 1'b1);  // One above
    set_row(12, 5'b00000, 16'h0020, 16'h0000, 14'h0320, 1'b0);
    set_row(13, 5'b00000, 16'h0060, 16'h0000, 14'h0360, 1'b0);  // LA17..16 ignored
    set_row(14, 5'b01000, 16'h0040, 16'h0000, 14'h0320, 1'b0);
    // First row after the writes reads the last written index
    set_row(15, 5'b10000, 16'h8000, 16'h0000, 14'h1680, 1'b1);
    set_row(16, 5'b10000, 16'h1400, 16'h0000, 14'h2580, 1'b1);
    set_row(17, 5'b10000, 16'hfc00, 16'h0000, 14'h30c0, 1'b1);
    set_row(18, 5'b10001, 16'h5400, 16'h0000, 14'h0f40, 1'b1);  // Extended paging
    set_row(19, 5'b10001, 16'h1400, 16'h0000, 14'h0580, 1'b1);
    set_row(20, 5'b10001, 16'hffff, 16'hffff, 14'h00c0, 1'b1);
    set_row(21, 5'b10101, 16'h8000, 16'h0000, 14'h0020, 1'b0);  // Shadow beats xpt_en
    set_row(22, 5'b00111, 16'h0000, 16'h7f80, 14'h0300, 1'b1);  // poni low beats all

    rng = 32'd89;
    for (int w = 0; w < NUM_WR_RAND; w++)
    begin
      rng        = xorshift(rng);
      wr_addr[w] = rng[5:0];
      rng        = xorshift(rng);
      wr_data[w] = rng[9:0];
    end
    wr_addr[16] = 6'h05;
    wr_data[16] = 10'h296;
    wr_addr[17] = 6'h15;
    wr_data[17] = 10'h13c;
    wr_addr[18] = 6'h3f;
    wr_data[18] = 10'h3c3;
    wr_addr[19] = 6'h20;  // Read back in the very next cycle
    wr_data[19] = 10'h05a;

    for (int i = 0; i < PT_DEPTH; i++)
      mirror[i] = '0;
    for (int w = 0; w < NUM_WR; w++)
      mirror[wr_addr[w]] = wr_data[w];  // Later writes win

    for (int r = NUM_DIR; r < NUM_ROWS; r++)
    begin
      rng = xorshift(rng);
      rows[r].mode = rng[4:0];
      rng = xorshift(rng);
      rows[r].ica = rng[31:16];
      rows[r].pcr = rng[15:0];
      rows[r].exp_la = model_la(rows[r].mode, rows[r].ica, rows[r].pcr,
                                mirror[rows[r].ica[15:10]]);
      rows[r].exp_hit_n = (rows[r].exp_la[5:0] != ECCR_WINDOW);
    end
  endtask

  // Compare the last applied row with la one cycle on
  task automatic check_pending();
    if (pend)
    begin
      assert (la === pend_la)
      else
      begin
        $display("Fail row %0d la got %h expected %h", pend_row, la, pend_la);
        la_errs++;
      end
      assert (eccr_hit_n === pend_hit)
      else
      begin
        $display("Fail row %0d eccr_hit_n got %h expected %h", pend_row, eccr_hit_n,
                 pend_hit);
        hit_errs++;
      end
      pend = 1'b0;
    end
  endtask

  task automatic apply_row(input int r);
    @(negedge mclk);
    check_pending();
    {poni, double, shadow, mreq, xpt_en} = rows[r].mode;
    ica      = rows[r].ica;
    pcr      = rows[r].pcr;
    pt_we    = 1'b0;
    pend     = 1'b1;
    pend_row = r;
    pend_la  = rows[r].exp_la;
    pend_hit = rows[r].exp_hit_n;
  endtask

  task automatic apply_write(input int w);
    @(negedge mclk);
    check_pending();
    pt_we    = 1'b1;
    pt_waddr = wr_addr[w];
    pt_wdata = wr_data[w];
  endtask

  // Watchdog sized from rows, writes and reset slack
  initial
  begin
    #(WDOG_CYCLES * CLK_PERIOD);
    $display("Timeout, the test sequence did not finish in %0d cycles", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    rst_n      = 1'b0;
    poni       = 1'b0;
    double     = 1'b0;
    shadow     = 1'b0;
    mreq       = 1'b0;
    xpt_en     = 1'b0;
    ica        = '0;
    pcr        = '0;
    pt_we      = 1'b0;
    pt_waddr   = '0;
    pt_wdata   = '0;
    pend       = 1'b0;
    pend_row   = 0;
    pend_la    = '0;
    pend_hit   = 1'b1;
    la_errs    = 0;
    hit_errs   = 0;
    other_errs = 0;
    fill_tables();

    repeat (4) @(posedge mclk);
    @(negedge mclk);
    rst_n = 1'b1;
    assert (la === 14'h0000)
    else
    begin
      $display("Fail after reset la got %h expected %h", la, 14'h0000);
      other_errs++;
    end
    assert (eccr_hit_n === 1'b1)
    else
    begin
      $display("Fail after reset eccr_hit_n got %h expected %h", eccr_hit_n, 1'b1);
      other_errs++;
    end

    for (int r = 0; r < NUM_A; r++)
      apply_row(r);
    for (int w = 0; w < NUM_WR; w++)
      apply_write(w);
    for (int r = NUM_A; r < NUM_ROWS; r++)
      apply_row(r);  // Back to back at one per cycle
    @(negedge mclk);
    check_pending();

    $display("Error counts: la %0d, eccr_hit_n %0d, other %0d", la_errs, hit_errs,
             other_errs);
    if (la_errs + hit_errs + other_errs == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hdl/mac_pkg.sv
hdl/mac_mode_decode.sv
hdl/mac_page_table.sv
hdl/mac_la_mux.sv
hdl/mac_top.sv
tests/tb_mac.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the mac_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_mac_sim

verilator --binary --timing --assert -f sim.f --top-module tb_mac -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build returned status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation binary returned status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
